/* spmd_loader_pkg.sv */
package spmd_loader_pkg;

  // --------------------
  // packet field widths and types
  // --------------------
  localparam int DATA_W = 32;
  typedef logic [DATA_W-1:0] data_t;  // payload or image word

  localparam int ADDR_W = 18;
  typedef logic [ADDR_W-1:0] addr_t;  // destination word address

  localparam int X_CORD_W = 4;
  localparam int Y_CORD_W = 4;
  typedef logic [X_CORD_W-1:0] x_cord_t;
  typedef logic [Y_CORD_W-1:0] y_cord_t;

  // --------------------
  // end-point address map
  // --------------------
  localparam int EPA_BYTE_ADDR_W = 16;

  // config space sits in the upper half of the end-point byte space
  localparam int CFG_BYTE_BASE = 1 << (EPA_BYTE_ADDR_W - 1);

  localparam int CSR_ORG_X_OFS = 4;  // group origin x csr
  localparam int CSR_ORG_Y_OFS = 8;  // group origin y csr

  localparam int ICACHE_BASE_WORD = 1 << 10;  // word address bit 10 selects icache
  localparam int DMEM_START_WORD  = 256;

  // --------------------
  // load phases, in sweep order
  // --------------------
  typedef enum logic [2:0] {
    PH_IDLE,
    PH_CFG,
    PH_ICACHE,
    PH_DMEM,
    PH_UNFREEZE,
    PH_DONE
  } phase_e;

endpackage

/* image_ram.sv */
module image_ram
  import spmd_loader_pkg::*;
#(
  parameter int ICACHE_ENTRIES = 16,
  parameter int DMEM_WORDS     = 8,
  localparam int IMG_DEPTH     = ICACHE_ENTRIES + DMEM_WORDS,
  localparam int IMG_AW        = $clog2(IMG_DEPTH)
) (
  input  logic              clk_i,

  // host side, used only while the loader is idle
  input  logic              we_i,
  input  logic [IMG_AW-1:0] waddr_i,
  input  data_t             wdata_i,

  // loader side
  input  logic              re_i,
  input  logic [IMG_AW-1:0] raddr_i,
  output data_t             rdata_o
);

  // instruction words first, data words directly after
  data_t mem_q [IMG_DEPTH];

  // --------------------
  // write port
  // --------------------
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // --------------------
  // registered read port
  // --------------------
  // rdata_o keeps its last word while re_i is low, the packet former
  // relies on that when its output stage stalls
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_o <= mem_q[raddr_i];
    end
  end

endmodule

/* tile_sweep_counter.sv */
module tile_sweep_counter
  import spmd_loader_pkg::*;
#(
  parameter int ICACHE_ENTRIES = 16,
  parameter int DMEM_WORDS     = 8,
  localparam int WORD_MAX      = (ICACHE_ENTRIES > DMEM_WORDS) ? ICACHE_ENTRIES : DMEM_WORDS,
  localparam int WORD_W        = $clog2((WORD_MAX > 2) ? WORD_MAX : 2)
) (
  input  logic              clk_i,
  input  logic              rst_n_i,

  input  phase_e            phase_i,
  input  logic              step_i,     // one item issued this cycle

  input  x_cord_t           tg_org_x_i,
  input  y_cord_t           tg_org_y_i,
  input  x_cord_t           tg_dim_x_i,
  input  y_cord_t           tg_dim_y_i,

  output x_cord_t           x_o,
  output y_cord_t           y_o,
  output logic [WORD_W-1:0] word_o,
  output logic              phase_last_o
);

  // offsets inside the tile group, so the origin never has to be loaded
  x_cord_t           x_ofs_q;
  y_cord_t           y_ofs_q;
  logic [WORD_W-1:0] word_q;

  logic [WORD_W-1:0] word_last;  // index of the last word in a tile
  logic              last_word;
  logic              last_x;
  logic              last_y;

  // --------------------
  // words per tile by phase
  // --------------------
  always_comb begin
    case (phase_i)
      PH_CFG:    word_last = WORD_W'(1);                  // origin x, origin y
      PH_ICACHE: word_last = WORD_W'(ICACHE_ENTRIES - 1);
      PH_DMEM:   word_last = WORD_W'(DMEM_WORDS - 1);
      default:   word_last = '0;                          // single unfreeze store
    endcase
  end

  assign last_word = (word_q == word_last);
  assign last_x    = (x_ofs_q == x_cord_t'(tg_dim_x_i - 1'b1));
  assign last_y    = (y_ofs_q == y_cord_t'(tg_dim_y_i - 1'b1));

  // --------------------
  // nested sweep, y outer, x inner, word innermost
  // --------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      x_ofs_q <= '0;
      y_ofs_q <= '0;
      word_q  <= '0;
    end else if (step_i) begin
      if (last_word) begin
        word_q <= '0;
        if (last_x) begin
          x_ofs_q <= '0;
          // wraps back to the origin once the whole group is done
          y_ofs_q <= last_y ? '0 : y_ofs_q + 1'b1;
        end else begin
          x_ofs_q <= x_ofs_q + 1'b1;
        end
      end else begin
        word_q <= word_q + 1'b1;
      end
    end
  end

  assign x_o          = tg_org_x_i + x_ofs_q;
  assign y_o          = tg_org_y_i + y_ofs_q;
  assign word_o       = word_q;
  assign phase_last_o = last_word & last_x & last_y;

endmodule

/* load_sequencer.sv */
module load_sequencer
  import spmd_loader_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_n_i,

  input  logic   start_i,
  input  logic   issue_i,        // packet former took an item
  input  logic   phase_last_i,   // that item closes the phase
  input  logic   drain_empty_i,  // pipeline empty after this cycle

  output phase_e phase_o,
  output logic   busy_o,
  output logic   done_o
);

  phase_e state_q;
  phase_e state_n;

  // --------------------
  // phase transitions
  // --------------------
  always_comb begin
    state_n = state_q;
    case (state_q)
      PH_IDLE: begin
        if (start_i) begin
          state_n = PH_CFG;
        end
      end
      PH_CFG: begin
        if (issue_i && phase_last_i) begin
          state_n = PH_ICACHE;
        end
      end
      PH_ICACHE: begin
        if (issue_i && phase_last_i) begin
          state_n = PH_DMEM;
        end
      end
      PH_DMEM: begin
        if (issue_i && phase_last_i) begin
          state_n = PH_UNFREEZE;
        end
      end
      PH_UNFREEZE: begin
        if (issue_i && phase_last_i) begin
          state_n = PH_DONE;
        end
      end
      PH_DONE: begin
        // wait for the last packets still in the pipeline
        if (drain_empty_i) begin
          state_n = PH_IDLE;
        end
      end
      default: state_n = PH_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= PH_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  // --------------------
  // outputs
  // --------------------
  // the start cycle already shows PH_CFG, so the first config store is
  // issued together with start_i and leaves two cycles later
  assign phase_o = (state_q == PH_IDLE && start_i) ? PH_CFG : state_q;

  assign done_o  = (state_q == PH_DONE) && drain_empty_i;  // on the final transfer
  assign busy_o  = (state_q != PH_IDLE) && !done_o;

endmodule

/* packet_former.sv */
module packet_former
  import spmd_loader_pkg::*;
#(
  parameter int ICACHE_ENTRIES = 16,
  parameter int DMEM_WORDS     = 8,
  localparam int IMG_AW        = $clog2(ICACHE_ENTRIES + DMEM_WORDS),
  localparam int WORD_MAX      = (ICACHE_ENTRIES > DMEM_WORDS) ? ICACHE_ENTRIES : DMEM_WORDS,
  localparam int WORD_W        = $clog2((WORD_MAX > 2) ? WORD_MAX : 2)
) (
  input  logic              clk_i,
  input  logic              rst_n_i,

  input  phase_e            phase_i,
  input  x_cord_t           x_i,
  input  y_cord_t           y_i,
  input  logic [WORD_W-1:0] word_i,
  input  x_cord_t           my_x_i,
  input  y_cord_t           my_y_i,
  input  x_cord_t           tg_org_x_i,
  input  y_cord_t           tg_org_y_i,
  input  data_t             rdata_i,
  input  logic              pkt_ready_i,

  output logic              issue_o,
  output logic              rd_en_o,
  output logic [IMG_AW-1:0] rd_addr_o,
  output logic              drain_empty_o,

  output logic              pkt_v_o,
  output addr_t             pkt_addr_o,
  output data_t             pkt_data_o,
  output x_cord_t           pkt_x_o,
  output y_cord_t           pkt_y_o,
  output x_cord_t           pkt_src_x_o,
  output y_cord_t           pkt_src_y_o
);

  logic    active;     // phase that produces packets
  logic    s2_ready;   // output register can take a new packet
  logic    s1_adv;     // stage 1 can take a new item
  addr_t   dst_addr;
  data_t   payload;

  logic    s1_v_q;
  phase_e  s1_phase_q;
  logic    s1_hi_q;    // second config store, origin y
  addr_t   s1_addr_q;
  x_cord_t s1_x_q;
  y_cord_t s1_y_q;

  // --------------------
  // stage 1: issue, image read, destination
  // --------------------
  assign active   = (phase_i == PH_CFG) || (phase_i == PH_ICACHE) ||
                    (phase_i == PH_DMEM) || (phase_i == PH_UNFREEZE);
  assign s2_ready = !pkt_v_o || pkt_ready_i;
  assign s1_adv   = !s1_v_q || s2_ready;
  assign issue_o  = active && s1_adv;

  assign rd_en_o   = issue_o && ((phase_i == PH_ICACHE) || (phase_i == PH_DMEM));
  assign rd_addr_o = (phase_i == PH_DMEM) ? IMG_AW'(ICACHE_ENTRIES) + IMG_AW'(word_i)
                                          : IMG_AW'(word_i);

  always_comb begin
    case (phase_i)
      PH_CFG: begin
        dst_addr = word_i[0] ? addr_t'((CFG_BYTE_BASE + CSR_ORG_Y_OFS) >> 2)
                             : addr_t'((CFG_BYTE_BASE + CSR_ORG_X_OFS) >> 2);
      end
      PH_ICACHE: dst_addr = addr_t'(ICACHE_BASE_WORD) | addr_t'(word_i);
      PH_DMEM:   dst_addr = addr_t'(DMEM_START_WORD) + addr_t'(word_i);
      default:   dst_addr = addr_t'(CFG_BYTE_BASE >> 2);  // unfreeze
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_v_q <= 1'b0;
    end else if (s1_adv) begin
      s1_v_q <= issue_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_o) begin
      s1_phase_q <= phase_i;
      s1_hi_q    <= word_i[0];
      s1_addr_q  <= dst_addr;
      s1_x_q     <= x_i;
      s1_y_q     <= y_i;
    end
  end

  // --------------------
  // stage 2: payload select and output register
  // --------------------
  always_comb begin
    case (s1_phase_q)
      PH_CFG:             payload = s1_hi_q ? data_t'(tg_org_y_i) : data_t'(tg_org_x_i);
      PH_ICACHE, PH_DMEM: payload = rdata_i;  // read issued with this item
      default:            payload = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pkt_v_o <= 1'b0;
    end else if (s2_ready) begin
      pkt_v_o <= s1_v_q;
    end
  end

  // fields only move when the register is free, so they hold under stall
  always_ff @(posedge clk_i) begin
    if (s2_ready && s1_v_q) begin
      pkt_addr_o  <= s1_addr_q;
      pkt_data_o  <= payload;
      pkt_x_o     <= s1_x_q;
      pkt_y_o     <= s1_y_q;
      pkt_src_x_o <= my_x_i;
      pkt_src_y_o <= my_y_i;
    end
  end

  assign drain_empty_o = !s1_v_q && s2_ready;  // nothing left after this cycle

endmodule

/* spmd_loader.sv */
module spmd_loader
  import spmd_loader_pkg::*;
#(
  parameter int ICACHE_ENTRIES = 16,
  parameter int DMEM_WORDS     = 8,
  localparam int IMG_AW        = $clog2(ICACHE_ENTRIES + DMEM_WORDS),
  localparam int WORD_MAX      = (ICACHE_ENTRIES > DMEM_WORDS) ? ICACHE_ENTRIES : DMEM_WORDS,
  localparam int WORD_W        = $clog2((WORD_MAX > 2) ? WORD_MAX : 2)
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              start_i,

  // host image write port
  input  logic              img_we_i,
  input  logic [IMG_AW-1:0] img_addr_i,
  input  data_t             img_wdata_i,

  // tile group, held stable while busy
  input  x_cord_t           tg_org_x_i,
  input  y_cord_t           tg_org_y_i,
  input  x_cord_t           tg_dim_x_i,
  input  y_cord_t           tg_dim_y_i,
  input  x_cord_t           my_x_i,
  input  y_cord_t           my_y_i,

  // remote store packets
  output logic              pkt_v_o,
  input  logic              pkt_ready_i,
  output addr_t             pkt_addr_o,
  output data_t             pkt_data_o,
  output x_cord_t           pkt_x_o,
  output y_cord_t           pkt_y_o,
  output x_cord_t           pkt_src_x_o,
  output y_cord_t           pkt_src_y_o,

  output logic              busy_o,
  output logic              done_o
);

  phase_e            phase;
  logic              issue;
  logic              phase_last;
  logic              drain_empty;
  x_cord_t           sweep_x;
  y_cord_t           sweep_y;
  logic [WORD_W-1:0] sweep_word;
  logic              rd_en;
  logic [IMG_AW-1:0] rd_addr;
  data_t             rdata;

  // --------------------
  // image store
  // --------------------
  image_ram #(
    .ICACHE_ENTRIES (ICACHE_ENTRIES),
    .DMEM_WORDS     (DMEM_WORDS)
  ) u_image_ram (
    .clk_i   (clk_i),
    .we_i    (img_we_i),
    .waddr_i (img_addr_i),
    .wdata_i (img_wdata_i),
    .re_i    (rd_en),
    .raddr_i (rd_addr),
    .rdata_o (rdata)
  );

  // --------------------
  // control
  // --------------------
  tile_sweep_counter #(
    .ICACHE_ENTRIES (ICACHE_ENTRIES),
    .DMEM_WORDS     (DMEM_WORDS)
  ) u_tile_sweep_counter (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .phase_i      (phase),
    .step_i       (issue),
    .tg_org_x_i   (tg_org_x_i),
    .tg_org_y_i   (tg_org_y_i),
    .tg_dim_x_i   (tg_dim_x_i),
    .tg_dim_y_i   (tg_dim_y_i),
    .x_o          (sweep_x),
    .y_o          (sweep_y),
    .word_o       (sweep_word),
    .phase_last_o (phase_last)
  );

  load_sequencer u_load_sequencer (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .start_i       (start_i),
    .issue_i       (issue),
    .phase_last_i  (phase_last),
    .drain_empty_i (drain_empty),
    .phase_o       (phase),
    .busy_o        (busy_o),
    .done_o        (done_o)
  );

  // --------------------
  // packet pipeline
  // --------------------
  packet_former #(
    .ICACHE_ENTRIES (ICACHE_ENTRIES),
    .DMEM_WORDS     (DMEM_WORDS)
  ) u_packet_former (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .phase_i       (phase),
    .x_i           (sweep_x),
    .y_i           (sweep_y),
    .word_i        (sweep_word),
    .my_x_i        (my_x_i),
    .my_y_i        (my_y_i),
    .tg_org_x_i    (tg_org_x_i),
    .tg_org_y_i    (tg_org_y_i),
    .rdata_i       (rdata),
    .pkt_ready_i   (pkt_ready_i),
    .issue_o       (issue),
    .rd_en_o       (rd_en),
    .rd_addr_o     (rd_addr),
    .drain_empty_o (drain_empty),
    .pkt_v_o       (pkt_v_o),
    .pkt_addr_o    (pkt_addr_o),
    .pkt_data_o    (pkt_data_o),
    .pkt_x_o       (pkt_x_o),
    .pkt_y_o       (pkt_y_o),
    .pkt_src_x_o   (pkt_src_x_o),
    .pkt_src_y_o   (pkt_src_y_o)
  );

endmodule

/* spmd_loader_tb.sv */
module spmd_loader_tb
  import spmd_loader_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ICACHE_ENTRIES = 16;
  localparam int DMEM_WORDS     = 8;
  localparam int IMG_DEPTH      = ICACHE_ENTRIES + DMEM_WORDS;
  localparam int IMG_AW         = $clog2(IMG_DEPTH);
  localparam int PKT_PER_TILE   = 3 + ICACHE_ENTRIES + DMEM_WORDS;
  localparam int CLK_PERIOD     = 4;
  localparam int N_CASES        = 3;

  typedef struct packed {
    x_cord_t    org_x;
    y_cord_t    org_y;
    x_cord_t    dim_x;
    y_cord_t    dim_y;
    x_cord_t    my_x;
    y_cord_t    my_y;
    logic [7:0] ready_pct;  // chance of pkt_ready per cycle
  } case_t;

  // --------------------
  // test table
  // --------------------
  localparam case_t CASES [N_CASES] = '{
    '{4'd2,  4'd3,  4'd1, 4'd1, 4'd0,  4'd0, 8'd100},
    '{4'd1,  4'd4,  4'd3, 4'd2, 4'd5,  4'd7, 8'd50},
    '{4'd15, 4'd14, 4'd2, 4'd3, 4'd15, 4'd1, 8'd25}   // coordinates wrap past 15
  };
  string case_names [N_CASES] = '{"single_tile_full_ready", "group_3x2_half_ready",
                                  "wrap_2x3_quarter_ready"};

  logic              clk;
  logic              rst_n;
  logic              start;
  logic              img_we;
  logic [IMG_AW-1:0] img_addr;
  data_t             img_wdata;
  x_cord_t           tg_org_x;
  y_cord_t           tg_org_y;
  x_cord_t           tg_dim_x;
  y_cord_t           tg_dim_y;
  x_cord_t           my_x;
  y_cord_t           my_y;
  logic              pkt_v;
  logic              pkt_ready;
  addr_t             pkt_addr;
  data_t             pkt_data;
  x_cord_t           pkt_x;
  y_cord_t           pkt_y;
  x_cord_t           pkt_src_x;
  y_cord_t           pkt_src_y;
  logic              busy;
  logic              done;

  integer  seed = 19288;
  int      value_errs = 0;
  int      flow_errs  = 0;
  data_t   img_model [IMG_DEPTH];
  addr_t   exp_addr [$];
  data_t   exp_data [$];
  x_cord_t exp_x [$];
  y_cord_t exp_y [$];

  spmd_loader #(
    .ICACHE_ENTRIES (ICACHE_ENTRIES),
    .DMEM_WORDS     (DMEM_WORDS)
  ) u_spmd_loader (
    .clk_i (clk), .rst_n_i (rst_n), .start_i (start),
    .img_we_i (img_we), .img_addr_i (img_addr), .img_wdata_i (img_wdata),
    .tg_org_x_i (tg_org_x), .tg_org_y_i (tg_org_y),
    .tg_dim_x_i (tg_dim_x), .tg_dim_y_i (tg_dim_y),
    .my_x_i (my_x), .my_y_i (my_y),
    .pkt_v_o (pkt_v), .pkt_ready_i (pkt_ready),
    .pkt_addr_o (pkt_addr), .pkt_data_o (pkt_data),
    .pkt_x_o (pkt_x), .pkt_y_o (pkt_y),
    .pkt_src_x_o (pkt_src_x), .pkt_src_y_o (pkt_src_y),
    .busy_o (busy), .done_o (done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------
  // compare tasks
  // --------------------
  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      $display("ERR %s addr: expected %h, actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      $display("ERR %s data: expected %h, actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_cord(input string name, input x_cord_t exp, input x_cord_t act);
    if (exp !== act) begin
      $display("ERR %s: expected %0d, actual %0d", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic flow_error(input string name, input string msg);
    $display("%s: %s", name, msg);
    flow_errs++;
  endtask

  function automatic logic ready_draw(input int pct);
    int r;
    r = $random(seed);
    return ((r & 32'h7fff_ffff) % 100) < pct;
  endfunction

  // reference packet list, phase by phase, y outer, x inner, word innermost
  task automatic build_expected(input case_t tc);
    int n_words;
    addr_t a;
    data_t d;
    exp_addr.delete();
    exp_data.delete();
    exp_x.delete();
    exp_y.delete();
    for (int ph = 0; ph < 4; ph++) begin
      n_words = (ph == 0) ? 2 : (ph == 1) ? ICACHE_ENTRIES : (ph == 2) ? DMEM_WORDS : 1;
      for (int y = 0; y < tc.dim_y; y++) begin
        for (int x = 0; x < tc.dim_x; x++) begin
          for (int w = 0; w < n_words; w++) begin
            case (ph)
              0: begin
                a = addr_t'((CFG_BYTE_BASE + ((w == 0) ? CSR_ORG_X_OFS : CSR_ORG_Y_OFS)) / 4);
                d = (w == 0) ? data_t'(tc.org_x) : data_t'(tc.org_y);
              end
              1: begin
                a = addr_t'(ICACHE_BASE_WORD) | addr_t'(w);
                d = img_model[w];
              end
              2: begin
                a = addr_t'(DMEM_START_WORD + w);
                d = img_model[ICACHE_ENTRIES + w];
              end
              default: begin
                a = addr_t'(CFG_BYTE_BASE / 4);  // unfreeze store
                d = '0;
              end
            endcase
            exp_addr.push_back(a);
            exp_data.push_back(d);
            exp_x.push_back(x_cord_t'(tc.org_x + x));
            exp_y.push_back(y_cord_t'(tc.org_y + y));
          end
        end
      end
    end
  endtask

  task automatic run_case(input int c);
    case_t   tc;
    string   name;
    string   tag;
    int      cyc;
    int      n_rx;
    int      total;
    bit      finished;
    bit      held;
    addr_t   h_addr;
    data_t   h_data;
    x_cord_t h_x;
    y_cord_t h_y;
    tc = CASES[c];
    name = case_names[c];
    @(posedge clk);
    #1;
    tg_org_x = tc.org_x;
    tg_org_y = tc.org_y;
    tg_dim_x = tc.dim_x;
    tg_dim_y = tc.dim_y;
    my_x     = tc.my_x;
    my_y     = tc.my_y;
    for (int i = 0; i < IMG_DEPTH; i++) begin  // host image fill
      img_we       = 1'b1;
      img_addr     = IMG_AW'(i);
      img_wdata    = $random(seed);
      img_model[i] = img_wdata;
      @(posedge clk);
      #1;
    end
    img_we = 1'b0;
    build_expected(tc);
    total = exp_addr.size();
    if (pkt_v || busy || done) flow_error(name, "outputs not idle before start");
    start     = 1'b1;
    pkt_ready = ready_draw(tc.ready_pct);
    cyc = 0;
    n_rx = 0;
    finished = 1'b0;
    held = 1'b0;
    while (!finished) begin
      @(negedge clk);  // everything settled, ready already driven for the next edge
      if (cyc == 1 && (pkt_v || !busy)) begin
        flow_error(name, "wrong busy or valid one cycle after start");
      end
      if (cyc == 2 && !pkt_v) flow_error(name, "first packet missing two cycles after start");
      if (held) begin
        if (!pkt_v) flow_error(name, "pkt_v_o dropped without a transfer");
        tag = {name, " hold"};
        check_addr(tag, h_addr, pkt_addr);
        check_data(tag, h_data, pkt_data);
        check_cord({tag, " x"}, h_x, pkt_x);
        check_cord({tag, " y"}, h_y, pkt_y);
      end
      if (pkt_v && pkt_ready) begin
        if (exp_addr.size() == 0) begin
          flow_error(name, "more packets than expected");
          finished = 1'b1;
        end else begin
          tag = $sformatf("%s pkt %0d", name, n_rx);
          n_rx++;
          check_addr(tag, exp_addr.pop_front(), pkt_addr);
          check_data(tag, exp_data.pop_front(), pkt_data);
          check_cord({tag, " x"}, exp_x.pop_front(), pkt_x);
          check_cord({tag, " y"}, exp_y.pop_front(), pkt_y);
          check_cord({tag, " src x"}, tc.my_x, pkt_src_x);
          check_cord({tag, " src y"}, tc.my_y, pkt_src_y);
          if (done != (n_rx == total)) flow_error(name, "done_o not on the final transfer");
          if (done && busy) flow_error(name, "busy_o still high on the final transfer");
          finished = done;
        end
      end else if (done) begin
        flow_error(name, "done_o without a transfer");
        finished = 1'b1;
      end
      held   = pkt_v && !pkt_ready;
      h_addr = pkt_addr;
      h_data = pkt_data;
      h_x    = pkt_x;
      h_y    = pkt_y;
      @(posedge clk);
      #1;
      start     = 1'b0;
      pkt_ready = ready_draw(tc.ready_pct);
      cyc++;
    end
    @(negedge clk);
    if (done || busy || pkt_v) flow_error(name, "loader not idle after done");
  endtask

  // --------------------
  // watchdog
  // --------------------
  initial begin : watchdog
    int limit;
    limit = 0;
    for (int c = 0; c < N_CASES; c++) begin
      limit += CASES[c].dim_x * CASES[c].dim_y * PKT_PER_TILE * 8 + 200;
    end
    #(limit * CLK_PERIOD);
    $display("timeout: the loader did not finish within %0d cycles", limit);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin : main
    rst_n     = 1'b0;
    start     = 1'b0;
    img_we    = 1'b0;
    img_addr  = '0;
    img_wdata = '0;
    tg_org_x  = '0;
    tg_org_y  = '0;
    tg_dim_x  = '0;
    tg_dim_y  = '0;
    my_x      = '0;
    my_y      = '0;
    pkt_ready = 1'b0;
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int c = 0; c < N_CASES; c++) begin
      run_case(c);
    end
    $display("value errors: %0d, protocol errors: %0d", value_errs, flow_errs);
    if (value_errs + flow_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* spmd_loader.f */
spmd_loader_pkg.sv
image_ram.sv
tile_sweep_counter.sv
load_sequencer.sv
packet_former.sv
spmd_loader.sv
spmd_loader_tb.sv

/* Bender.yml */
package:
  name: spmd_loader

sources:
  - spmd_loader_pkg.sv
  - image_ram.sv
  - tile_sweep_counter.sv
  - load_sequencer.sv
  - packet_former.sv
  - spmd_loader.sv
  - target: test
    files:
      - spmd_loader_tb.sv
